//--- exec_pkg.sv
`default_nettype none

package exec_pkg;

  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;

  // bubble cycles of one multiply
  localparam int MUL_STAGES = 3;

  // major opcodes
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

  // funct7 variants
  localparam logic [6:0] F7_BASE   = 7'b0000000;
  localparam logic [6:0] F7_ALT    = 7'b0100000;
  localparam logic [6:0] F7_MULDIV = 7'b0000001;

  // funct3 values with MUL in the add slot
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_SLTU    = 3'b011;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SR      = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  typedef enum logic [3:0] {
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_ADD,
    ALU_SUB,
    ALU_SHIFT_LEFT,
    ALU_SHIFT_RIGHT,
    ALU_SHIFT_RIGHT_AR,
    ALU_LESS_THAN_UNSIGNED,
    ALU_LESS_THAN_SIGNED,
    ALU_EQUAL,
    ALU_MUL
  } alu_op_t;

endpackage

`default_nettype wire

//--- issue_if.sv
`default_nettype none

interface issue_if;
  import exec_pkg::*;

  logic                  valid;
  logic                  ready;
  alu_op_t               op;
  logic                  inv_res;
  logic [REG_ADDR_W-1:0] rs1;
  logic [REG_ADDR_W-1:0] rs2;
  // raw register file values driven at the top level
  logic [XLEN-1:0]       rs1_val;
  logic [XLEN-1:0]       rs2_val;
  logic                  use_imm;
  logic [XLEN-1:0]       imm;
  logic [REG_ADDR_W-1:0] rd;
  logic                  wb_en;

  modport producer (
    output valid, op, inv_res, rs1, rs2, use_imm, imm, rd, wb_en
  );

  modport consumer (
    input  valid, op, inv_res, rs1, rs2, rs1_val, rs2_val, use_imm, imm, rd, wb_en,
    output ready
  );

endinterface

`default_nettype wire

//--- decoder.sv
`default_nettype none

module decoder (
  input  logic [31:0] instr,
  issue_if.producer   id,
  input  logic        instr_valid
);
  import exec_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  alu_op_t    op;
  logic       inv_res;
  logic       use_imm;
  logic       legal;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  always_comb begin
    op      = ALU_ADD;
    inv_res = 1'b0;
    use_imm = 1'b0;
    legal   = 1'b0;
    case (opcode)
      OPC_OP: begin
        case (funct7)
          F7_BASE: begin
            legal = 1'b1;
            case (funct3)
              F3_ADD_SUB: op = ALU_ADD;
              F3_SLL:     op = ALU_SHIFT_LEFT;
              F3_SLT:     op = ALU_LESS_THAN_SIGNED;
              F3_SLTU:    op = ALU_LESS_THAN_UNSIGNED;
              F3_XOR:     op = ALU_XOR;
              F3_SR:      op = ALU_SHIFT_RIGHT;
              F3_OR:      op = ALU_OR;
              F3_AND:     op = ALU_AND;
            endcase
          end
          F7_ALT: begin
            if (funct3 == F3_ADD_SUB) begin
              op    = ALU_SUB;
              legal = 1'b1;
            end else if (funct3 == F3_SR) begin
              op    = ALU_SHIFT_RIGHT_AR;
              legal = 1'b1;
            end else if (funct3 == F3_XOR) begin
              // xnor is xor with the result inverted
              op      = ALU_XOR;
              inv_res = 1'b1;
              legal   = 1'b1;
            end
          end
          F7_MULDIV: begin
            // plain MUL only without high halves or DIV/REM
            if (funct3 == F3_ADD_SUB) begin
              op    = ALU_MUL;
              legal = 1'b1;
            end
          end
          default: legal = 1'b0;
        endcase
      end
      OPC_OP_IMM: begin
        use_imm = 1'b1;
        case (funct3)
          F3_ADD_SUB: begin
            op    = ALU_ADD;
            legal = 1'b1;
          end
          F3_SLT: begin
            op    = ALU_LESS_THAN_SIGNED;
            legal = 1'b1;
          end
          F3_SLTU: begin
            op    = ALU_LESS_THAN_UNSIGNED;
            legal = 1'b1;
          end
          F3_XOR: begin
            op    = ALU_XOR;
            legal = 1'b1;
          end
          F3_OR: begin
            op    = ALU_OR;
            legal = 1'b1;
          end
          F3_AND: begin
            op    = ALU_AND;
            legal = 1'b1;
          end
          F3_SLL: begin
            op    = ALU_SHIFT_LEFT;
            legal = (funct7 == F7_BASE);
          end
          F3_SR: begin
            // shamt sits in the low five immediate bits
            op    = (funct7 == F7_ALT) ? ALU_SHIFT_RIGHT_AR : ALU_SHIFT_RIGHT;
            legal = (funct7 == F7_BASE) || (funct7 == F7_ALT);
          end
        endcase
      end
      default: legal = 1'b0;
    endcase
  end

  assign id.valid   = instr_valid;
  assign id.op      = op;
  assign id.inv_res = inv_res;
  assign id.rs1     = instr[19:15];
  assign id.rs2     = instr[24:20];
  assign id.rd      = instr[11:7];
  assign id.use_imm = use_imm;
  assign id.imm     = {{(XLEN - 12){instr[31]}}, instr[31:20]};
  assign id.wb_en   = legal;

endmodule

`default_nettype wire

//--- regfile.sv
`default_nettype none

module regfile (
  input  logic                            clk,
  input  logic                            rst,
  input  logic [exec_pkg::REG_ADDR_W-1:0] raddr1,
  input  logic [exec_pkg::REG_ADDR_W-1:0] raddr2,
  output logic [exec_pkg::XLEN-1:0]       rdata1,
  output logic [exec_pkg::XLEN-1:0]       rdata2,
  input  logic                            we,
  input  logic [exec_pkg::REG_ADDR_W-1:0] waddr,
  input  logic [exec_pkg::XLEN-1:0]       wdata
);
  import exec_pkg::*;

  logic [XLEN-1:0] regs [2**REG_ADDR_W];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 2**REG_ADDR_W; i++) begin
        regs[i] <= '0;
      end
    end else if (we && waddr != '0) begin
      regs[waddr] <= wdata;
    end
  end

  // x0 stays zero because writes to it are dropped
  assign rdata1 = regs[raddr1];
  assign rdata2 = regs[raddr2];

  a_x0_zero: assert property (
    @(posedge clk) disable iff (rst)
    (raddr1 != '0 || rdata1 == '0) && (raddr2 != '0 || rdata2 == '0)
  ) else $error("x0 read back non-zero");

endmodule

`default_nettype wire

//--- alu.sv
`default_nettype none

module alu (
  input  logic                      clk,
  input  logic                      rst,
  input  logic [exec_pkg::XLEN-1:0] left_operand,
  input  logic [exec_pkg::XLEN-1:0] right_operand,
  input  exec_pkg::alu_op_t         alu_op,
  input  logic                      alu_inv_res,
  output logic [exec_pkg::XLEN-1:0] alu_res,
  output logic                      insert_bubble
);
  import exec_pkg::*;

  localparam int CNT_W = $clog2(MUL_STAGES + 1);
  localparam logic [CNT_W-1:0] CNT_DONE = MUL_STAGES[CNT_W-1:0];

  logic [XLEN-1:0]  internal_res;
  logic [4:0]       shamt;
  logic [XLEN-1:0]  left_operand_d;
  logic [XLEN-1:0]  right_operand_d;
  logic [XLEN-1:0]  mul_res;
  logic [XLEN-1:0]  mul_res_d;
  logic [XLEN-1:0]  mul_res_dd;
  logic [CNT_W-1:0] mul_cnt;

  // RV32 shifts look at five bits only
  assign shamt = right_operand[4:0];

  always_comb begin
    case (alu_op)
      ALU_AND:            internal_res = left_operand & right_operand;
      ALU_OR:             internal_res = left_operand | right_operand;
      ALU_XOR:            internal_res = left_operand ^ right_operand;
      ALU_ADD:            internal_res = left_operand + right_operand;
      ALU_SUB:            internal_res = left_operand - right_operand;
      ALU_SHIFT_LEFT:     internal_res = left_operand << shamt;
      ALU_SHIFT_RIGHT:    internal_res = left_operand >> shamt;
      ALU_SHIFT_RIGHT_AR: internal_res = $signed(left_operand) >>> shamt;
      ALU_LESS_THAN_UNSIGNED: begin
        internal_res = {{(XLEN - 1){1'b0}}, left_operand < right_operand};
      end
      ALU_LESS_THAN_SIGNED: begin
        internal_res = {{(XLEN - 1){1'b0}}, $signed(left_operand) < $signed(right_operand)};
      end
      ALU_EQUAL: begin
        internal_res = {{(XLEN - 1){1'b0}}, left_operand == right_operand};
      end
      ALU_MUL:            internal_res = mul_res_dd;
      default:            internal_res = left_operand + right_operand;
    endcase
  end

  // multiplier pipe with operand regs and two product stages
  always_ff @(posedge clk) begin
    left_operand_d  <= left_operand;
    right_operand_d <= right_operand;
    mul_res_d       <= mul_res;
    mul_res_dd      <= mul_res_d;
  end

  // low half is the same for signed and unsigned
  assign mul_res = left_operand_d * right_operand_d;

  always_ff @(posedge clk) begin
    if (rst) begin
      mul_cnt <= '0;
    end else if (mul_cnt == CNT_DONE) begin
      mul_cnt <= '0;
    end else if (mul_cnt != '0 || alu_op == ALU_MUL) begin
      mul_cnt <= mul_cnt + 1'b1;
    end
  end

  assign insert_bubble = (alu_op == ALU_MUL && mul_cnt == '0) ||
                         (mul_cnt != '0 && mul_cnt != CNT_DONE);

  assign alu_res = alu_inv_res ? ~internal_res : internal_res;

  a_cnt_with_mul: assert property (
    @(posedge clk) disable iff (rst) mul_cnt != '0 |-> alu_op == ALU_MUL
  ) else $error("multiply counter running without a multiply");

endmodule

`default_nettype wire

//--- execute_stage.sv
`default_nettype none

module execute_stage (
  input  logic                            clk,
  input  logic                            rst,
  issue_if.consumer                       id,
  output logic                            wb_valid,
  output logic [exec_pkg::REG_ADDR_W-1:0] wb_rd,
  output logic [exec_pkg::XLEN-1:0]       wb_data
);
  import exec_pkg::*;

  logic                  ex_valid;
  alu_op_t               ex_op;
  logic                  ex_inv;
  logic [XLEN-1:0]       ex_a;
  logic [XLEN-1:0]       ex_b;
  logic [REG_ADDR_W-1:0] ex_rd;
  logic                  ex_wb_en;
  logic                  ex_wr;
  alu_op_t               alu_op;
  logic [XLEN-1:0]       alu_res;
  logic                  bubble;
  logic                  take;
  logic [XLEN-1:0]       fwd_a;
  logic [XLEN-1:0]       fwd_b;

  // execute register beats writeback, which beats the regfile
  function automatic logic [XLEN-1:0] forward(input logic [REG_ADDR_W-1:0] rs,
                                              input logic [XLEN-1:0] rf_val);
    if (rs != '0 && ex_wr && ex_rd == rs) begin
      return alu_res;
    end else if (rs != '0 && wb_valid && wb_rd == rs) begin
      return wb_data;
    end
    return rf_val;
  endfunction

  assign ex_wr    = ex_valid && ex_wb_en && (ex_rd != '0);
  assign id.ready = !(ex_valid && bubble);
  assign take     = id.valid && id.ready;

  always_comb begin
    fwd_a = forward(id.rs1, id.rs1_val);
    fwd_b = forward(id.rs2, id.rs2_val);
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      ex_valid <= 1'b0;
    end else if (id.ready) begin
      ex_valid <= id.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      ex_op    <= id.op;
      ex_inv   <= id.inv_res;
      ex_a     <= fwd_a;
      ex_b     <= id.use_imm ? id.imm : fwd_b;
      ex_rd    <= id.rd;
      ex_wb_en <= id.wb_en;
    end
  end

  // an empty slot must not start a multiply
  always_comb begin
    if (ex_valid) begin
      alu_op = ex_op;
    end else begin
      alu_op = ALU_AND;
    end
  end

  alu u_alu (
    .clk           (clk),
    .rst           (rst),
    .left_operand  (ex_a),
    .right_operand (ex_b),
    .alu_op        (alu_op),
    .alu_inv_res   (ex_inv),
    .alu_res       (alu_res),
    .insert_bubble (bubble)
  );

  always_ff @(posedge clk) begin
    if (rst) begin
      wb_valid <= 1'b0;
    end else begin
      wb_valid <= ex_wr && !bubble;
    end
  end

  always_ff @(posedge clk) begin
    wb_rd   <= ex_rd;
    wb_data <= alu_res;
  end

  a_hold_in_bubble: assert property (
    @(posedge clk) disable iff (rst)
    (ex_valid && bubble) |=> (ex_valid && $stable(ex_op) && $stable(ex_a) &&
                              $stable(ex_b) && $stable(ex_rd))
  ) else $error("execute register changed during multiply stall");

endmodule

`default_nettype wire

//--- exec_core.sv
`default_nettype none

module exec_core (
  input  logic        clk,
  input  logic        rst,
  input  logic        instr_valid,
  input  logic [31:0] instr,
  output logic        instr_ready,
  output logic        wb_valid,
  output logic [4:0]  wb_rd,
  output logic [31:0] wb_data
);

  issue_if id ();

  decoder u_decoder (
    .instr       (instr),
    .id          (id.producer),
    .instr_valid (instr_valid)
  );

  // register values go straight into the issue bundle
  regfile u_regfile (
    .clk    (clk),
    .rst    (rst),
    .raddr1 (id.rs1),
    .raddr2 (id.rs2),
    .rdata1 (id.rs1_val),
    .rdata2 (id.rs2_val),
    .we     (wb_valid),
    .waddr  (wb_rd),
    .wdata  (wb_data)
  );

  execute_stage u_execute_stage (
    .clk      (clk),
    .rst      (rst),
    .id       (id.consumer),
    .wb_valid (wb_valid),
    .wb_rd    (wb_rd),
    .wb_data  (wb_data)
  );

  assign instr_ready = id.ready;

endmodule

`default_nettype wire

//--- tb_exec_core.sv
`default_nettype none

module tb_exec_core;
  import exec_pkg::*;

  localparam int NUM_INSTR     = 400;
  localparam int READY_TIMEOUT = 10;
  localparam int DRAIN_TIMEOUT = 20;

  logic        clk;
  logic        rst;
  logic        instr_valid;
  logic [31:0] instr;
  logic        instr_ready;
  logic        wb_valid;
  logic [4:0]  wb_rd;
  logic [31:0] wb_data;

  integer      seed;
  int          cycle   = 0;
  int          mul_acc = -100;
  logic [31:0] mregs [32];
  logic [4:0]  exp_rd [$];
  logic [31:0] exp_data [$];
  int          exp_due [$];

  exec_core DUT (
    .clk         (clk),
    .rst         (rst),
    .instr_valid (instr_valid),
    .instr       (instr),
    .instr_ready (instr_ready),
    .wb_valid    (wb_valid),
    .wb_rd       (wb_rd),
    .wb_data     (wb_data)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("** Error at time %0t: %s is %h, expected %h", $time, what, got, exp);
      $display("Result: FAILED");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  task automatic abort_run(input string why);
    $display("%s at time %0t", why, $time);
    $display("Result: FAILED");
    $fatal(1, "run aborted");
  endtask

  // RV32 result of a base function where alt picks SUB or SRA
  function automatic logic [31:0] base_rule(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'b000: return alt ? a - b : a + b;
      3'b001: return a << b[4:0];
      3'b010: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'b011: return (a < b) ? 32'd1 : 32'd0;
      3'b100: return a ^ b;
      3'b101: begin
        if (alt) begin
          return $signed(a) >>> b[4:0];
        end
        return a >> b[4:0];
      end
      3'b110: return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic void model_exec(input logic [31:0] word, input logic [31:0] a,
                                     input logic [31:0] b, output logic wr,
                                     output logic [31:0] res);
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [31:0] imm;
    f3  = word[14:12];
    f7  = word[31:25];
    imm = {{20{word[31]}}, word[31:20]};
    wr  = 1'b0;
    res = '0;
    if (word[6:0] == OPC_OP) begin
      if (f7 == F7_BASE) begin
        wr  = 1'b1;
        res = base_rule(f3, 1'b0, a, b);
      end else if (f7 == F7_ALT && (f3 == 3'b000 || f3 == 3'b101)) begin
        wr  = 1'b1;
        res = base_rule(f3, 1'b1, a, b);
      end else if (f7 == F7_ALT && f3 == 3'b100) begin
        wr  = 1'b1;
        res = ~(a ^ b);
      end else if (f7 == F7_MULDIV && f3 == 3'b000) begin
        wr  = 1'b1;
        res = a * b;
      end
    end else if (word[6:0] == OPC_OP_IMM) begin
      if (f3 == 3'b001) begin
        wr = (f7 == F7_BASE);
      end else if (f3 == 3'b101) begin
        wr = (f7 == F7_BASE) || (f7 == F7_ALT);
      end else begin
        wr = 1'b1;
      end
      res = base_rule(f3, f3 == 3'b101 && f7 == F7_ALT, a, imm);
    end
  endfunction

  // one falling edge with instr_ready checked against the last multiply
  task automatic next_cycle();
    @(negedge clk);
    if (cycle >= mul_acc && cycle <= mul_acc + 2) begin
      check_value("instr_ready during multiply", 32'(instr_ready), 32'd0);
    end else begin
      check_value("instr_ready outside a multiply", 32'(instr_ready), 32'd1);
    end
  endtask

  task automatic model_issue(input logic [31:0] word, input int acc);
    logic [31:0] res;
    logic        wr;
    logic        is_mul;
    logic [4:0]  rd;
    rd     = word[11:7];
    is_mul = (word[6:0] == OPC_OP) && (word[31:25] == F7_MULDIV) && (word[14:12] == 3'b000);
    model_exec(word, mregs[word[19:15]], mregs[word[24:20]], wr, res);
    if (is_mul) begin
      mul_acc = acc;
    end
    if (wr && rd != 5'd0) begin
      mregs[rd] = res;
      exp_rd.push_back(rd);
      exp_data.push_back(res);
      exp_due.push_back(is_mul ? acc + MUL_STAGES + 1 : acc + 1);
    end
  endtask

  task automatic pick_reg(output logic [4:0] idx);
    logic [31:0] r;
    r = $random(seed);
    // mostly x0..x7 so hazards are frequent
    idx = (r[7:5] == 3'd0) ? r[4:0] : {2'b00, r[2:0]};
  endtask

  task automatic gen_instr(output logic [31:0] word);
    logic [31:0] r;
    int          kind;
    logic [6:0]  opc;
    logic [6:0]  f7;
    logic [2:0]  f3;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    pick_reg(rd);
    pick_reg(rs1);
    pick_reg(rs2);
    r    = $random(seed);
    kind = {$random(seed)} % 20;
    f3   = r[2:0];
    f7   = F7_BASE;
    opc  = OPC_OP;
    if (kind == 7 || kind == 8 || kind == 9) begin
      f7 = F7_ALT;
      f3 = (kind == 7) ? 3'b000 : (kind == 8) ? 3'b101 : 3'b100;
    end else if (kind == 10 || kind == 11) begin
      f7 = F7_MULDIV;
      f3 = 3'b000;
    end else if (kind >= 12 && kind < 18) begin
      opc = OPC_OP_IMM;
      f7  = (f3 == 3'b101 && r[3]) ? F7_ALT : F7_BASE;
      rs2 = r[20:16];
    end else if (kind == 18) begin
      // high multiplies and DIV/REM
      f7 = F7_MULDIV;
      f3 = (f3 == 3'b000) ? 3'b100 : f3;
    end else if (kind == 19) begin
      opc = r[3] ? 7'b0000011 : 7'b0110111;
    end
    if (opc == OPC_OP_IMM && f3 != 3'b001 && f3 != 3'b101) begin
      word = {r[15:4], rs1, f3, rd, opc};
    end else begin
      word = {f7, rs2, rs1, f3, rd, opc};
    end
  endtask

  task automatic send_instr(input logic [31:0] word);
    int waited;
    instr_valid = 1'b1;
    instr       = word;
    waited      = 0;
    while (instr_ready !== 1'b1) begin
      next_cycle();
      waited++;
      if (waited > READY_TIMEOUT) begin
        abort_run("instr_ready stayed low too long");
      end
    end
    // taken at the coming rising edge
    model_issue(word, cycle + 1);
    next_cycle();
    instr_valid = 1'b0;
    instr       = $random(seed);
  endtask

  always @(negedge clk) begin
    if (wb_valid === 1'b1) begin
      if (exp_due.size() == 0) begin
        abort_run("writeback seen with no result pending");
      end else begin
        check_value("wb_rd", 32'(wb_rd), 32'(exp_rd.pop_front()));
        check_value("wb_data", wb_data, exp_data.pop_front());
        check_value("writeback cycle", cycle, exp_due.pop_front());
      end
    end else if (exp_due.size() != 0 && exp_due[0] < cycle) begin
      abort_run("expected writeback never arrived");
    end
  end

  initial begin
    logic [31:0] word;
    logic [31:0] r;
    int          waited;
    seed        = 45347;
    rst         = 1'b1;
    instr_valid = 1'b0;
    instr       = '0;
    for (int i = 0; i < 32; i++) begin
      mregs[i] = '0;
    end
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    next_cycle();
    check_value("wb_valid after reset", 32'(wb_valid), 32'd0);
    check_value("instr_ready after reset", 32'(instr_ready), 32'd1);
    for (int n = 0; n < NUM_INSTR; n++) begin
      gen_instr(word);
      send_instr(word);
      r = $random(seed);
      if (r[1:0] == 2'b00) begin
        repeat (1 + r[3:2]) next_cycle();
      end
    end
    waited = 0;
    while (exp_due.size() != 0) begin
      next_cycle();
      waited++;
      if (waited > DRAIN_TIMEOUT) begin
        abort_run("writebacks still pending after the last instruction");
      end
    end
    repeat (4) next_cycle();
    $display("Result: PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- exec_core.f
exec_pkg.sv
issue_if.sv
decoder.sv
regfile.sv
alu.sv
execute_stage.sv
exec_core.sv
tb_exec_core.sv

//--- Makefile
TB_TOP = tb_exec_core

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f exec_core.f --top-module exec_core
	verilator --lint-only --timing -f exec_core.f --top-module $(TB_TOP)

sim:
	verilator --binary --timing --assert -f exec_core.f --top-module $(TB_TOP)
	out=$$(./obj_dir/V$(TB_TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q '^Result: PASSED$$'

clean:
	rm -rf obj_dir
